//--- Bender.yml
package:
  name: inst_buffer

sources:
  - source/inst_buffer_pkg.sv
  - source/line_window_if.sv
  - source/slot_if.sv
  - source/fetch_line_queue.sv
  - source/parcel_extractor.sv
  - source/dispatch_grouper.sv
  - source/inst_buffer_top.sv
  - target: test
    files:
      - bench/clock_gen.sv
      - bench/tb_inst_buffer.sv

//--- bench/clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module clock_gen #(
  parameter real PERIOD_NS    = 8.0,
  parameter int  RESET_CYCLES = 2
) (
  output logic o_clk,
  output logic o_reset_n
);

  initial begin
    o_clk     = 1'b0;
    o_reset_n = 1'b0;
  end

  always #(PERIOD_NS / 2.0) o_clk = ~o_clk;

  // Release on a rising edge
  initial begin
    repeat (RESET_CYCLES) @(posedge o_clk);
    o_reset_n <= 1'b1;
  end

endmodule

`default_nettype wire

//--- bench/tb_inst_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module tb_inst_buffer;

  localparam int DW      = inst_buffer_pkg::DISP_WIDTH_DEF;
  localparam int TIMEOUT = 2000;

  logic                                clk;
  logic                                reset_n;
  logic                                flush;
  logic                                line_valid;
  logic                                line_ready;
  logic [31:0]                         line_pc;
  logic [63:0]                         line_data;
  logic                                disp_valid;
  logic                                disp_ready;
  logic [1:0]                          disp_count;
  logic [DW-1:0][31:0]                 disp_inst;
  logic [DW-1:0][31:0]                 disp_pc;
  inst_buffer_pkg::inst_cat_e [DW-1:0] disp_cat;
  logic [DW-1:0]                       disp_comp;

  logic [31:0] exp_inst[$];                      // Expected stream in program order
  logic [31:0] exp_pc[$];
  logic [15:0] parcels[$];
  logic [63:0] line_q[$];
  logic [31:0] line_pc_q[$];
  logic [31:0] rng;
  logic [31:0] next_pc;
  logic [31:0] line_addr;
  logic        exp_ready;
  string       test_name;
  int          lines_in;                         // Lines accepted since the last flush
  int          parcels_out;                      // Parcels dispatched since the last flush
  int          errors;
  int          start_errors;
  int          tests_run;
  int          tests_failed;

  clock_gen #(.PERIOD_NS(8.0), .RESET_CYCLES(2)) u_clock (.o_clk(clk), .o_reset_n(reset_n));

  inst_buffer_top DUT (
    .i_clk (clk), .i_reset_n (reset_n), .i_flush (flush),
    .i_line_valid (line_valid), .o_line_ready (line_ready),
    .i_line_pc (line_pc), .i_line_data (line_data),
    .o_disp_valid (disp_valid), .i_disp_ready (disp_ready),
    .o_disp_count (disp_count), .o_disp_inst (disp_inst), .o_disp_pc (disp_pc),
    .o_disp_cat (disp_cat), .o_disp_compressed (disp_comp)
  );

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // Taps 32 22 2 1
  endfunction

  function automatic int draw(input int nbits);
    int v;
    v = 0;
    for (int i = 0; i < nbits; i++) begin
      v   = (v << 1) | int'(rng[0]);
      rng = lfsr_next(rng);
    end
    return v;
  endfunction

  function automatic logic [31:0] table_word(input int idx);
    case (idx)
      0:       return 32'h0015_0513;            // addi
      1:       return 32'h0005_a503;            // lw
      2:       return 32'h00b5_0463;            // beq
      3:       return 32'hffff_ffff;            // illegal
      4:       return 32'h0000_0505;            // c.addi
      5:       return 32'h0000_4188;            // c.lw
      6:       return 32'h0000_a001;            // c.j
      default: return 32'h0000_852e;            // c.mv
    endcase
  endfunction

  function automatic inst_buffer_pkg::inst_cat_e ref_cat(input logic [31:0] w);
    if (w[1:0] != 2'b11) begin
      if (w[15:0] == 16'h0000) return inst_buffer_pkg::CAT_ILLEGAL;
      if (w[1:0] == 2'b00) return inst_buffer_pkg::CAT_MEM;
      if (w[1:0] == 2'b01 && w[15:13] >= 3'd5) return inst_buffer_pkg::CAT_BR;
      return inst_buffer_pkg::CAT_ARITH;
    end
    case (w[6:0])
      7'h03, 7'h23:                return inst_buffer_pkg::CAT_MEM;
      7'h63, 7'h6f, 7'h67:         return inst_buffer_pkg::CAT_BR;
      7'h13, 7'h33, 7'h37, 7'h17:  return inst_buffer_pkg::CAT_ARITH;
      default:                     return inst_buffer_pkg::CAT_ILLEGAL;
    endcase
  endfunction

  // A line pops once all its parcels are dispatched
  function automatic int lines_held();
    return lines_in - parcels_out / 4;
  endfunction

  // Largest group the limits and the accepted lines allow from the head of the expected list
  function automatic int expected_count();
    int n;
    int mem;
    int br;
    int avail;
    n     = 0;
    mem   = 0;
    br    = 0;
    avail = lines_in * 4 - parcels_out;
    while (n < DW && n < exp_inst.size()) begin
      if (n > 0 && ref_cat(exp_inst[n-1]) == inst_buffer_pkg::CAT_ILLEGAL) break;
      if (ref_cat(exp_inst[n]) == inst_buffer_pkg::CAT_MEM) mem++;
      if (ref_cat(exp_inst[n]) == inst_buffer_pkg::CAT_BR) br++;
      if (mem > inst_buffer_pkg::MEM_PER_GROUP || br > inst_buffer_pkg::BR_PER_GROUP) break;
      avail -= (exp_inst[n][1:0] == 2'b11) ? 2 : 1;
      if (avail < 0) break;                       // Parcel not yet in the buffer
      n++;
    end
    return n;
  endfunction

  task automatic value_error(input string what, input logic [31:0] exp, input logic [31:0] act);
    $display("CHECK FAILED %s %s: expected %h actual %h", test_name, what, exp, act);
    errors++;
  endtask

  task automatic fail_plain(input string msg);
    $display("ERROR in %s: %s", test_name, msg);
    errors++;
  endtask

  task automatic add_inst(input logic [31:0] word);
    exp_inst.push_back(word);
    exp_pc.push_back(next_pc);
    parcels.push_back(word[15:0]);
    next_pc += 2;
    if (word[1:0] == 2'b11) begin
      parcels.push_back(word[31:16]);
      next_pc += 2;
    end
  endtask

  // Pad with c.nop to a whole line and cut the parcels into lines
  task automatic close_stream();
    while (parcels.size() % 4 != 0) add_inst(32'h0000_0001);
    while (parcels.size() != 0) begin
      line_q.push_back({parcels[3], parcels[2], parcels[1], parcels[0]});
      line_pc_q.push_back(line_addr);
      line_addr += 8;
      repeat (4) void'(parcels.pop_front());
    end
  endtask

  task automatic push_lines();
    int waited;
    while (line_q.size() != 0) begin
      @(posedge clk);
      line_valid <= 1'b1;
      line_data  <= line_q.pop_front();
      line_pc    <= line_pc_q.pop_front();
      waited = 0;
      do begin
        @(negedge clk);
        waited++;
      end while (!line_ready && waited < TIMEOUT);
      if (!line_ready) fail_plain("timeout, line never accepted");
    end
    @(posedge clk);
    line_valid <= 1'b0;
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    while (exp_inst.size() != 0 && waited < TIMEOUT) begin
      @(posedge clk);
      waited++;
    end
    if (exp_inst.size() != 0) fail_plain("timeout, instructions never dispatched");
    @(negedge clk);
    assert (!disp_valid) else fail_plain("dispatch continues past the end of the stream");
  endtask

  task automatic run_random();
    int  cycles;
    logic taken;
    cycles = 0;
    while ((line_q.size() != 0 || exp_inst.size() != 0) && cycles < TIMEOUT) begin
      @(negedge clk);
      taken = line_valid && line_ready;
      @(posedge clk);
      cycles++;
      disp_ready <= (draw(2) != 0);
      if (taken || !line_valid) begin
        if (line_q.size() != 0 && draw(1) == 1) begin
          line_valid <= 1'b1;
          line_data  <= line_q.pop_front();
          line_pc    <= line_pc_q.pop_front();
        end else begin
          line_valid <= 1'b0;
        end
      end
    end
    if (cycles >= TIMEOUT) fail_plain("timeout in random traffic");
    drain();
  endtask

  task automatic begin_test(input string name);
    test_name    = name;
    start_errors = errors;
    tests_run++;
  endtask

  task automatic end_test();
    @(posedge clk);
    disp_ready <= 1'b0;
    if (errors != start_errors) tests_failed++;
    $display("test %s: %0d errors", test_name, errors - start_errors);
  endtask

  task automatic check_group();
    int n;
    n = expected_count();
    assert (disp_count == n) else value_error("count", n, disp_count);
    for (int k = 0; k < DW; k++) begin
      if (k >= disp_count) begin
        assert (disp_inst[k] == '0) else value_error("unused slot", 0, disp_inst[k]);
      end else if (exp_inst.size() == 0) begin
        fail_plain("instruction dispatched beyond the stream");
      end else begin
        assert (disp_inst[k] == exp_inst[0]) else value_error("inst", exp_inst[0], disp_inst[k]);
        assert (disp_pc[k] == exp_pc[0]) else value_error("pc", exp_pc[0], disp_pc[k]);
        assert (disp_cat[k] == ref_cat(exp_inst[0]))
          else value_error("cat", 32'(ref_cat(exp_inst[0])), 32'(disp_cat[k]));
        assert (disp_comp[k] == (exp_inst[0][1:0] != 2'b11))
          else value_error("compressed", 32'(exp_inst[0][1:0] != 2'b11), 32'(disp_comp[k]));
        parcels_out += (exp_inst[0][1:0] == 2'b11) ? 2 : 1;
        void'(exp_inst.pop_front());
        void'(exp_pc.pop_front());
      end
    end
  endtask

  // Outputs settle by the falling edge and transfer on the rising one
  always @(negedge clk) begin
    if (reset_n && flush) begin
      assert (!disp_valid) else fail_plain("dispatch valid during flush");
      exp_inst.delete();
      exp_pc.delete();
      lines_in    = 0;
      parcels_out = 0;
    end else if (reset_n) begin
      exp_ready = (lines_held() < inst_buffer_pkg::QUEUE_DEPTH_DEF);
      assert (line_ready == exp_ready)
        else value_error("line ready", 32'(exp_ready), 32'(line_ready));
      if (disp_valid && disp_ready) check_group();
      if (line_valid && line_ready) lines_in++;
    end
  end

  initial begin
    int waited;
    flush      <= 1'b0;
    line_valid <= 1'b0;
    line_pc    <= '0;
    line_data  <= '0;
    disp_ready <= 1'b0;
    rng          = 32'ha361_a8eb;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    lines_in     = 0;
    parcels_out  = 0;
    next_pc      = 32'h0000_1000;
    line_addr    = 32'h0000_1000;
    test_name    = "reset";
    waited       = 0;
    while (!reset_n && waited < TIMEOUT) begin
      @(posedge clk);
      waited++;
    end
    @(negedge clk);
    assert (reset_n && !disp_valid && line_ready) else fail_plain("bad state after reset");

    begin_test("arith32");
    for (int k = 0; k < 8; k++) add_inst(32'h0000_0093 | (32'(k) << 20));
    close_stream();
    push_lines();
    @(negedge clk);
    assert (!line_ready) else fail_plain("line ready high with four lines held");
    @(posedge clk);
    disp_ready <= 1'b1;
    drain();
    end_test();

    begin_test("mixed");
    add_inst(32'h0000_0505);
    add_inst(32'h0015_0513);
    add_inst(32'h00b5_0533);                     // Crosses into line 1
    while (parcels.size() < 15) add_inst(table_word(draw(3)));
    close_stream();
    push_lines();
    @(posedge clk);
    disp_ready <= 1'b1;
    drain();
    end_test();

    begin_test("limits");
    add_inst(32'h0005_a503);
    add_inst(32'h00a5_a223);
    add_inst(32'h0000_0505);                     // Lets beq and jal meet in one group
    add_inst(32'h00b5_0463);
    add_inst(32'h0100_006f);
    add_inst(32'hffff_ffff);
    add_inst(32'h0000_4188);
    add_inst(32'h0015_0513);
    close_stream();
    push_lines();
    @(posedge clk);
    disp_ready <= 1'b1;
    drain();
    end_test();

    begin_test("random");
    while (parcels.size() < 60) add_inst(table_word(draw(3)));
    close_stream();
    run_random();
    end_test();

    begin_test("flush");
    add_inst(32'h0005_a503);
    add_inst(32'h00a5_a223);
    add_inst(32'h0015_0513);
    add_inst(32'h0025_0513);
    close_stream();
    push_lines();
    @(posedge clk);
    disp_ready <= 1'b1;                          // Only lw goes and the offset stops at parcel 2
    @(posedge clk);
    disp_ready <= 1'b0;
    flush      <= 1'b1;
    @(posedge clk);
    flush      <= 1'b0;
    next_pc   = 32'h0000_8000;
    line_addr = 32'h0000_8000;
    add_inst(32'h0000_0505);
    add_inst(32'h0035_0513);
    close_stream();
    push_lines();
    @(posedge clk);
    disp_ready <= 1'b1;
    drain();
    end_test();

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- inst_buffer_top.f
source/inst_buffer_pkg.sv
source/line_window_if.sv
source/slot_if.sv
source/fetch_line_queue.sv
source/parcel_extractor.sv
source/dispatch_grouper.sv
source/inst_buffer_top.sv
bench/clock_gen.sv
bench/tb_inst_buffer.sv

//--- source/dispatch_grouper.sv
`timescale 1ns/1ps
`default_nettype none

module dispatch_grouper #(
  parameter int DISP_WIDTH = inst_buffer_pkg::DISP_WIDTH_DEF
) (
  input  logic                                               i_flush,
  slot_if.grouper                                            slots,
  output logic                                               o_disp_valid,
  input  logic                                               i_disp_ready,
  output logic [$clog2(DISP_WIDTH+1)-1:0]                    o_disp_count,
  output logic [DISP_WIDTH-1:0][inst_buffer_pkg::INST_W-1:0] o_disp_inst,
  output logic [DISP_WIDTH-1:0][inst_buffer_pkg::PC_W-1:0]   o_disp_pc,
  output inst_buffer_pkg::inst_cat_e [DISP_WIDTH-1:0]        o_disp_cat,
  output logic [DISP_WIDTH-1:0]                              o_disp_compressed
);

  localparam int CNT_W = $clog2(DISP_WIDTH + 1);

  logic [CNT_W-1:0] w_count;

  // ========================================
  // Group selection
  // ========================================
  always_comb begin
    int                         mem_cnt;
    int                         br_cnt;
    logic                       stop;
    logic                       seen_illegal;
    inst_buffer_pkg::inst_cat_e cat;
    mem_cnt           = 0;
    br_cnt            = 0;
    stop              = 1'b0;
    seen_illegal      = 1'b0;
    w_count           = '0;
    o_disp_inst       = '0;
    o_disp_pc         = '0;
    o_disp_compressed = '0;
    for (int k = 0; k < DISP_WIDTH; k++) begin
      o_disp_cat[k] = inst_buffer_pkg::CAT_ARITH;
    end
    for (int k = 0; k < DISP_WIDTH; k++) begin
      cat = inst_buffer_pkg::classify_inst(slots.slot_inst[k]);
      if (!slots.slot_valid[k] || seen_illegal) begin
        stop = 1'b1;                                   // Gap or after illegal
      end else if (cat == inst_buffer_pkg::CAT_MEM &&
                   mem_cnt >= inst_buffer_pkg::MEM_PER_GROUP) begin
        stop = 1'b1;
      end else if (cat == inst_buffer_pkg::CAT_BR &&
                   br_cnt >= inst_buffer_pkg::BR_PER_GROUP) begin
        stop = 1'b1;
      end
      if (!stop) begin
        w_count              = w_count + 1'b1;
        o_disp_inst[k]       = slots.slot_inst[k];
        o_disp_pc[k]         = slots.slot_pc[k];
        o_disp_cat[k]        = cat;
        o_disp_compressed[k] = slots.slot_compressed[k];
        if (cat == inst_buffer_pkg::CAT_MEM)     mem_cnt = mem_cnt + 1;
        if (cat == inst_buffer_pkg::CAT_BR)      br_cnt = br_cnt + 1;
        if (cat == inst_buffer_pkg::CAT_ILLEGAL) seen_illegal = 1'b1;
      end
    end
  end

  assign o_disp_count     = w_count;
  assign o_disp_valid     = (w_count != '0) & !i_flush;
  assign slots.fire       = o_disp_valid & i_disp_ready;
  assign slots.take_count = w_count;

endmodule

`default_nettype wire

//--- source/fetch_line_queue.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_line_queue #(
  parameter int LINE_BITS   = inst_buffer_pkg::LINE_BITS_DEF,
  parameter int QUEUE_DEPTH = inst_buffer_pkg::QUEUE_DEPTH_DEF
) (
  input  logic                              i_clk,
  input  logic                              i_reset_n,
  input  logic                              i_flush,
  input  logic                              i_line_valid,
  output logic                              o_line_ready,
  input  logic [inst_buffer_pkg::PC_W-1:0]  i_line_pc,
  input  logic [LINE_BITS-1:0]              i_line_data,
  line_window_if.queue                      win
);

  localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;

  logic [LINE_BITS-1:0]              r_data [QUEUE_DEPTH];
  logic [inst_buffer_pkg::PC_W-1:0]  r_pc   [QUEUE_DEPTH];
  logic [QUEUE_DEPTH-1:0]            r_valid;
  logic [PTR_W-1:0]                  r_in_ptr;
  logic [PTR_W-1:0]                  r_out_ptr;
  logic [PTR_W-1:0]                  w_out_ptr_p1;
  logic                              w_wr_fire;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign o_line_ready = !(&r_valid);
  assign w_wr_fire    = i_line_valid & o_line_ready;
  assign w_out_ptr_p1 = ptr_inc(r_out_ptr);

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid   <= '0;
      r_in_ptr  <= '0;
      r_out_ptr <= '0;
    end else if (i_flush) begin
      r_valid   <= '0;
      r_in_ptr  <= '0;
      r_out_ptr <= '0;
    end else begin
      if (w_wr_fire) begin
        r_valid[r_in_ptr] <= 1'b1;
        r_in_ptr          <= ptr_inc(r_in_ptr);
      end
      if (win.pop) begin
        r_valid[r_out_ptr] <= 1'b0;
        r_out_ptr          <= w_out_ptr_p1;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_wr_fire) begin
      r_data[r_in_ptr] <= i_line_data;
      r_pc[r_in_ptr]   <= i_line_pc;
    end
  end

  assign win.head_valid = r_valid[r_out_ptr];
  assign win.head_data  = r_data[r_out_ptr];
  assign win.head_pc    = r_pc[r_out_ptr];
  assign win.next_valid = r_valid[w_out_ptr_p1];
  assign win.next_data  = r_data[w_out_ptr_p1];

  // In pointer must always land on a free entry
  a_no_overwrite: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (w_wr_fire && !i_flush) |-> !r_valid[r_in_ptr]);

endmodule

`default_nettype wire

//--- source/inst_buffer_pkg.sv
`default_nettype none

package inst_buffer_pkg;

  localparam int PC_W            = 32;
  localparam int PARCEL_W        = 16;
  localparam int INST_W          = 32;
  localparam int LINE_BITS_DEF   = 64;
  localparam int DISP_WIDTH_DEF  = 2;
  localparam int QUEUE_DEPTH_DEF = 4;
  localparam int MEM_PER_GROUP   = 1;
  localparam int BR_PER_GROUP    = 1;

  typedef enum logic [1:0] {
    CAT_ARITH,
    CAT_MEM,
    CAT_BR,
    CAT_ILLEGAL
  } inst_cat_e;

  function automatic inst_cat_e classify_inst(input logic [INST_W-1:0] inst);
    inst_cat_e cat;
    if (inst[1:0] != 2'b11) begin
      if (inst[15:0] == 16'h0000) begin
        cat = CAT_ILLEGAL;
      end else begin
        case (inst[1:0])
          2'b00:   cat = CAT_MEM;
          2'b01:   cat = (inst[15:13] inside {3'b101, 3'b110, 3'b111}) ? CAT_BR : CAT_ARITH;
          default: cat = CAT_ARITH;
        endcase
      end
    end else begin
      case (inst[6:0])
        7'b0000011, 7'b0100011:             cat = CAT_MEM;   // Load, store
        7'b1100011, 7'b1101111, 7'b1100111: cat = CAT_BR;    // Branch, jal, jalr
        7'b0010011, 7'b0110011,
        7'b0110111, 7'b0010111:             cat = CAT_ARITH;
        default:                            cat = CAT_ILLEGAL;
      endcase
    end
    return cat;
  endfunction

endpackage

`default_nettype wire

//--- source/inst_buffer_top.sv
`timescale 1ns/1ps
`default_nettype none

module inst_buffer_top #(
  parameter int LINE_BITS   = inst_buffer_pkg::LINE_BITS_DEF,
  parameter int DISP_WIDTH  = inst_buffer_pkg::DISP_WIDTH_DEF,
  parameter int QUEUE_DEPTH = inst_buffer_pkg::QUEUE_DEPTH_DEF
) (
  input  logic                                               i_clk,
  input  logic                                               i_reset_n,
  input  logic                                               i_flush,

  // Fetch side
  input  logic                                               i_line_valid,
  output logic                                               o_line_ready,
  input  logic [inst_buffer_pkg::PC_W-1:0]                   i_line_pc,
  input  logic [LINE_BITS-1:0]                               i_line_data,

  // Dispatch side
  output logic                                               o_disp_valid,
  input  logic                                               i_disp_ready,
  output logic [$clog2(DISP_WIDTH+1)-1:0]                    o_disp_count,
  output logic [DISP_WIDTH-1:0][inst_buffer_pkg::INST_W-1:0] o_disp_inst,
  output logic [DISP_WIDTH-1:0][inst_buffer_pkg::PC_W-1:0]   o_disp_pc,
  output inst_buffer_pkg::inst_cat_e [DISP_WIDTH-1:0]        o_disp_cat,
  output logic [DISP_WIDTH-1:0]                              o_disp_compressed
);

  line_window_if #(.LINE_BITS(LINE_BITS)) u_win ();
  slot_if #(.DISP_WIDTH(DISP_WIDTH)) u_slots ();

  fetch_line_queue #(
    .LINE_BITS   (LINE_BITS),
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) u_queue (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_flush      (i_flush),
    .i_line_valid (i_line_valid),
    .o_line_ready (o_line_ready),
    .i_line_pc    (i_line_pc),
    .i_line_data  (i_line_data),
    .win          (u_win.queue)
  );

  parcel_extractor #(
    .LINE_BITS  (LINE_BITS),
    .DISP_WIDTH (DISP_WIDTH)
  ) u_extractor (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_flush   (i_flush),
    .win       (u_win.extractor),
    .slots     (u_slots.extractor)
  );

  dispatch_grouper #(.DISP_WIDTH(DISP_WIDTH)) u_grouper (
    .i_flush           (i_flush),
    .slots             (u_slots.grouper),
    .o_disp_valid      (o_disp_valid),
    .i_disp_ready      (i_disp_ready),
    .o_disp_count      (o_disp_count),
    .o_disp_inst       (o_disp_inst),
    .o_disp_pc         (o_disp_pc),
    .o_disp_cat        (o_disp_cat),
    .o_disp_compressed (o_disp_compressed)
  );

endmodule

`default_nettype wire

//--- source/line_window_if.sv
`timescale 1ns/1ps
`default_nettype none

// Head line and its successor, as seen by the boundary logic
interface line_window_if #(
  parameter int LINE_BITS = inst_buffer_pkg::LINE_BITS_DEF
);

  logic                              head_valid;
  logic [LINE_BITS-1:0]              head_data;
  logic [inst_buffer_pkg::PC_W-1:0]  head_pc;
  logic                              next_valid;
  logic [LINE_BITS-1:0]              next_data;
  logic                              pop;         // Retire head line

  modport queue (
    output head_valid, head_data, head_pc, next_valid, next_data,
    input  pop
  );

  modport extractor (
    input  head_valid, head_data, head_pc, next_valid, next_data,
    output pop
  );

endinterface

`default_nettype wire

//--- source/parcel_extractor.sv
`timescale 1ns/1ps
`default_nettype none

module parcel_extractor #(
  parameter int LINE_BITS  = inst_buffer_pkg::LINE_BITS_DEF,
  parameter int DISP_WIDTH = inst_buffer_pkg::DISP_WIDTH_DEF
) (
  input  logic            i_clk,
  input  logic            i_reset_n,
  input  logic            i_flush,
  line_window_if.extractor win,
  slot_if.extractor       slots
);

  localparam int PW    = inst_buffer_pkg::PARCEL_W;
  localparam int PPL   = LINE_BITS / PW;          // Parcels per line
  localparam int OFF_W = $clog2(PPL);
  localparam int IDX_W = $clog2(2 * PPL) + 1;

  logic [OFF_W-1:0]       r_offset;
  logic [2*LINE_BITS-1:0] w_window;
  logic [IDX_W-1:0]       w_idx [DISP_WIDTH+1];
  logic [IDX_W-1:0]       w_next_idx;
  logic                   w_pop;

  // Empty lines read as zero parcels
  assign w_window = {win.next_valid ? win.next_data : {LINE_BITS{1'b0}},
                     win.head_valid ? win.head_data : {LINE_BITS{1'b0}}};

  // ========================================
  // Boundary walk
  // ========================================
  always_comb begin
    logic [PW-1:0]    lo;
    logic [PW-1:0]    hi;
    logic [IDX_W-1:0] last;
    logic             is_c;
    logic             chain;
    chain    = win.head_valid;
    w_idx[0] = IDX_W'(r_offset);
    for (int k = 0; k < DISP_WIDTH; k++) begin
      lo = '0;
      hi = '0;
      if (w_idx[k] < 2 * PPL) lo = w_window[w_idx[k]*PW +: PW];
      if (w_idx[k] + 1 < 2 * PPL) hi = w_window[(w_idx[k]+1)*PW +: PW];
      is_c       = (lo[1:0] != 2'b11);
      w_idx[k+1] = w_idx[k] + (is_c ? IDX_W'(1) : IDX_W'(2));
      last       = w_idx[k+1] - 1'b1;                  // Last parcel of slot
      chain      = chain & ((last < PPL) | ((last < 2 * PPL) & win.next_valid));
      slots.slot_valid[k]      = chain;
      slots.slot_compressed[k] = is_c;
      slots.slot_inst[k]       = is_c ? {{(inst_buffer_pkg::INST_W - PW){1'b0}}, lo}
                                      : {hi, lo};
      slots.slot_pc[k]         = win.head_pc
                                 + inst_buffer_pkg::PC_W'({w_idx[k], 1'b0});
    end
  end

  always_comb begin
    w_next_idx = w_idx[0];
    for (int k = 1; k <= DISP_WIDTH; k++) begin
      if (slots.take_count == k) w_next_idx = w_idx[k];
    end
  end

  assign w_pop   = slots.fire & (w_next_idx >= PPL);   // Group reached next line
  assign win.pop = w_pop;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_offset <= '0;
    end else if (i_flush) begin
      r_offset <= '0;
    end else if (w_pop) begin
      r_offset <= OFF_W'(w_next_idx - PPL);            // Carry the excess
    end else if (slots.fire) begin
      r_offset <= OFF_W'(w_next_idx);
    end
  end

  a_pop_needs_head: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    w_pop |-> win.head_valid);

endmodule

`default_nettype wire

//--- source/slot_if.sv
`timescale 1ns/1ps
`default_nettype none

interface slot_if #(
  parameter int DISP_WIDTH = inst_buffer_pkg::DISP_WIDTH_DEF
);

  localparam int CNT_W = $clog2(DISP_WIDTH + 1);

  // Located instructions, in program order
  logic [DISP_WIDTH-1:0]                               slot_valid;
  logic [DISP_WIDTH-1:0][inst_buffer_pkg::INST_W-1:0]  slot_inst;
  logic [DISP_WIDTH-1:0]                               slot_compressed;
  logic [DISP_WIDTH-1:0][inst_buffer_pkg::PC_W-1:0]    slot_pc;

  // Group handshake back to the extractor
  logic                                                fire;
  logic [CNT_W-1:0]                                    take_count;

  modport extractor (
    output slot_valid, slot_inst, slot_compressed, slot_pc,
    input  fire, take_count
  );

  modport grouper (
    input  slot_valid, slot_inst, slot_compressed, slot_pc,
    output fire, take_count
  );

endinterface

`default_nettype wire
